// ==== seq_config.svh ====
`ifndef SEQ_CONFIG_SVH
`define SEQ_CONFIG_SVH

// program counter and instruction address width.
`define SEQ_PC_W 8

// words in the instruction memory.
`define SEQ_IMEM_DEPTH 256

// opcode and reserved field widths of an instruction word.
`define SEQ_OP_W 4
`define SEQ_RSVD_W 4

`endif

// ==== seqPkg.sv ====
`default_nettype none

package seqPkg;

	// one phase level high at a time.
	typedef struct packed {
		logic stopped;
		logic fetch;
		logic decode;
		logic execute;
		logic commit;
	} phaseT;

	localparam phaseT phStopped = 5'b10000;
	localparam phaseT phFetch   = 5'b01000;
	localparam phaseT phDecode  = 5'b00100;
	localparam phaseT phExecute = 5'b00010;
	localparam phaseT phCommit  = 5'b00001;

	typedef struct packed {
		logic debugReq; // pulse.
		logic modeStop; // level.
		logic modeInc;  // pulse, one step.
	} debugCtlT;

endpackage

`default_nettype wire

// ==== isaPkg.sv ====
`default_nettype none

`include "seq_config.svh"

package isaPkg;

	// anything not listed runs as a nop.
	typedef enum logic [`SEQ_OP_W-1:0] {
		NOP  = 4'h0,
		JMP  = 4'h1,
		LOAD = 4'h2,
		HALT = 4'hf
	} opcodeT;

	typedef struct packed {
		opcodeT                 opcode;
		logic [`SEQ_RSVD_W-1:0] rsvd;
		logic [`SEQ_PC_W-1:0]   target;
	} jumpViewT;

	typedef struct packed {
		opcodeT                 opcode;
		logic [`SEQ_RSVD_W-1:0] rsvd;
		logic [`SEQ_PC_W-1:0]   dataAddr;
	} loadViewT;

	// same word, jump or load reading.
	typedef union packed {
		jumpViewT jump;
		loadViewT load;
	} instrT;

	typedef struct packed {
		logic                 isHalt;
		logic                 isJump;
		logic                 isLoad;
		logic [`SEQ_PC_W-1:0] target;
		logic [`SEQ_PC_W-1:0] dataAddr;
	} decodedT;

endpackage

`default_nettype wire

// ==== masterSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module masterSequencer (
	input  wire logic              clk,
	input  wire logic              rstN,
	input  wire seqPkg::debugCtlT  dbg,
	input  wire logic              atBkp,
	input  wire logic              inWatch,
	input  wire isaPkg::decodedT   dec,
	output seqPkg::phaseT          phase,
	output logic                   pcEn,
	output logic                   halted,
	output logic                   debugActive,
	output logic                   debugAck
);

	logic reqFlag;   // debug request seen, not yet served.
	logic stepping;  // running one instruction under debug.
	logic stopCause;
	logic holdCause;
	logic stepStart;

	// checked at the commit boundary.
	assign stopCause = dbg.modeStop | dbg.debugReq | reqFlag | atBkp | inWatch | stepping;

	// keeps a debug stop from resuming.
	assign holdCause = dbg.modeStop | dbg.debugReq | reqFlag | atBkp | inWatch;

	assign stepStart = phase.stopped & debugActive & ~halted & dbg.modeInc;

	// a halt leaves the pc where it is.
	assign pcEn = phase.commit & ~dec.isHalt;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			reqFlag <= 1'b0;
		end else begin
			reqFlag <= dbg.debugReq | (reqFlag & ~stepStart);
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			phase       <= seqPkg::phStopped;
			stepping    <= 1'b0;
			halted      <= 1'b0;
			debugActive <= 1'b0;
			debugAck    <= 1'b0;
		end else begin
			debugAck <= 1'b0;
			if (phase.fetch) begin
				phase <= seqPkg::phDecode;
			end else if (phase.decode) begin
				phase <= seqPkg::phExecute;
			end else if (phase.execute) begin
				phase <= seqPkg::phCommit;
			end else if (phase.commit) begin
				if (dec.isHalt) begin
					phase       <= seqPkg::phStopped;
					halted      <= 1'b1; // only reset gets out.
					debugActive <= 1'b0;
					stepping    <= 1'b0;
				end else if (stopCause) begin
					phase       <= seqPkg::phStopped;
					debugActive <= 1'b1;
					debugAck    <= 1'b1;
					stepping    <= 1'b0;
				end else begin
					phase <= seqPkg::phFetch;
				end
			end else if (!halted) begin
				// stopped.
				if (!debugActive) begin
					phase <= seqPkg::phFetch; // first run after reset.
				end else if (stepStart) begin
					phase    <= seqPkg::phFetch;
					stepping <= 1'b1;
				end else if (!holdCause) begin
					phase       <= seqPkg::phFetch;
					debugActive <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== instrFetch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "seq_config.svh"

module instrFetch (
	input  wire logic                 clk,
	input  wire seqPkg::phaseT        phase,
	input  wire logic [`SEQ_PC_W-1:0] pc,
	input  wire logic                 imemWe,
	input  wire logic [`SEQ_PC_W-1:0] imemAddr,
	input  wire isaPkg::instrT        imemData,
	output isaPkg::instrT             instr
);

	isaPkg::instrT mem [`SEQ_IMEM_DEPTH];

	// program load port.
	always_ff @(posedge clk) begin
		if (imemWe) begin
			mem[imemAddr] <= imemData;
		end
	end

	// instruction register.
	always_ff @(posedge clk) begin
		if (phase.fetch) begin
			instr <= mem[pc];
		end
	end

endmodule

`default_nettype wire

// ==== instrDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecode (
	input  wire logic            clk,
	input  wire logic            rstN,
	input  wire seqPkg::phaseT   phase,
	input  wire isaPkg::instrT   instr,
	output isaPkg::decodedT      dec
);

	isaPkg::decodedT decNext;

	always_comb begin
		decNext = '0;
		case (instr.jump.opcode)
			isaPkg::JMP: begin
				decNext.isJump = 1'b1;
				decNext.target = instr.jump.target;
			end
			isaPkg::LOAD: begin
				decNext.isLoad   = 1'b1;
				decNext.dataAddr = instr.load.dataAddr;
			end
			isaPkg::HALT: decNext.isHalt = 1'b1;
			default: decNext = '0; // nop.
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dec <= '0;
		end else if (phase.decode) begin
			dec <= decNext;
		end
	end

endmodule

`default_nettype wire

// ==== debugMatch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "seq_config.svh"

module debugMatch (
	input  wire logic                 clk,
	input  wire logic                 rstN,
	input  wire seqPkg::phaseT        phase,
	input  wire logic [`SEQ_PC_W-1:0] pc,
	input  wire isaPkg::decodedT      dec,
	input  wire logic                 bkpEn,
	input  wire logic [`SEQ_PC_W-1:0] bkpAddr,
	input  wire logic                 watchEn,
	input  wire logic [`SEQ_PC_W-1:0] watchAddr,
	output logic                      atBkp,
	output logic                      inWatch
);

	logic bkpHit;
	logic watchHit;

	assign bkpHit   = bkpEn & (pc == bkpAddr);
	assign watchHit = watchEn & dec.isLoad & (dec.dataAddr == watchAddr);

	// held through commit, dropped at the next fetch.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			atBkp   <= 1'b0;
			inWatch <= 1'b0;
		end else if (phase.fetch) begin
			atBkp   <= 1'b0;
			inWatch <= 1'b0;
		end else if (phase.execute) begin
			atBkp   <= bkpHit;
			inWatch <= watchHit;
		end
	end

endmodule

`default_nettype wire

// ==== programCounter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "seq_config.svh"

module programCounter (
	input  wire logic            clk,
	input  wire logic            rstN,
	input  wire seqPkg::phaseT   phase,
	input  wire logic            pcEn,
	input  wire isaPkg::decodedT dec,
	output logic [`SEQ_PC_W-1:0] pc
);

	logic [`SEQ_PC_W-1:0] pcNext;

	// wraps at the top of memory.
	assign pcNext = dec.isJump ? dec.target : pc + 1'b1;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (phase.commit && pcEn) begin
			pc <= pcNext;
		end
	end

endmodule

`default_nettype wire

// ==== seqTop.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "seq_config.svh"

module seqTop (
	input  wire logic                 clk,
	input  wire logic                 rstN,
	input  wire logic                 imemWe,
	input  wire logic [`SEQ_PC_W-1:0] imemAddr,
	input  wire isaPkg::instrT        imemData,
	input  wire seqPkg::debugCtlT     dbg,
	input  wire logic                 bkpEn,
	input  wire logic [`SEQ_PC_W-1:0] bkpAddr,
	input  wire logic                 watchEn,
	input  wire logic [`SEQ_PC_W-1:0] watchAddr,
	output seqPkg::phaseT             phase,
	output logic [`SEQ_PC_W-1:0]      pc,
	output logic                      halted,
	output logic                      debugActive,
	output logic                      debugAck
);

	isaPkg::instrT   instr;
	isaPkg::decodedT dec;
	logic            atBkp;
	logic            inWatch;
	logic            pcEn;

	masterSequencer seq0 (
		.clk(clk), .rstN(rstN), .dbg(dbg),
		.atBkp(atBkp), .inWatch(inWatch), .dec(dec),
		.phase(phase), .pcEn(pcEn), .halted(halted),
		.debugActive(debugActive), .debugAck(debugAck)
	);

	instrFetch fetch0 (
		.clk(clk), .phase(phase), .pc(pc),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.instr(instr)
	);

	instrDecode decode0 (
		.clk(clk), .rstN(rstN), .phase(phase), .instr(instr), .dec(dec)
	);

	debugMatch match0 (
		.clk(clk), .rstN(rstN), .phase(phase), .pc(pc), .dec(dec),
		.bkpEn(bkpEn), .bkpAddr(bkpAddr),
		.watchEn(watchEn), .watchAddr(watchAddr),
		.atBkp(atBkp), .inWatch(inWatch)
	);

	programCounter pc0 (
		.clk(clk), .rstN(rstN), .phase(phase), .pcEn(pcEn), .dec(dec), .pc(pc)
	);

endmodule

`default_nettype wire

// ==== seq_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module seqProps (
	input wire logic          clk,
	input wire logic          rstN,
	input wire seqPkg::phaseT phase,
	input wire logic          halted,
	input wire logic          debugActive,
	input wire logic          debugAck
);

	logic [4:0] phaseBits;

	assign phaseBits = phase;

	phaseOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot(phaseBits))
		else $error("phase is not one-hot");

	ackWhenStopped: assert property (@(posedge clk) disable iff (!rstN)
		debugAck |-> phase.stopped)
		else $error("debugAck outside the stopped phase");

	// fetch only after a boundary.
	fetchOrder: assert property (@(posedge clk) disable iff (!rstN)
		phase.fetch |-> $past(phase.commit || phase.stopped))
		else $error("fetch did not follow commit or stopped");

	stopKinds: assert property (@(posedge clk) disable iff (!rstN) !(halted && debugActive))
		else $error("halted and debugActive both high");

endmodule

`default_nettype wire

// ==== seqTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "seq_config.svh"

module seqTb;

	typedef logic [`SEQ_PC_W-1:0] pcT;

	localparam int cycleLimit = 2000; // roughly three times the whole run.
	localparam pcT jmpTarget = 'h40;
	localparam seqPkg::phaseT phStop  = 5'b10000;
	localparam seqPkg::phaseT phFetch = 5'b01000;
	localparam seqPkg::phaseT phDec   = 5'b00100;
	localparam seqPkg::phaseT phExe   = 5'b00010;
	localparam seqPkg::phaseT phCom   = 5'b00001;

	logic             clk = 1'b0;
	logic             rstN;
	logic             imemWe;
	pcT               imemAddr;
	isaPkg::instrT    imemData;
	seqPkg::debugCtlT dbg;
	logic             bkpEn;
	pcT               bkpAddr;
	logic             watchEn;
	pcT               watchAddr;
	seqPkg::phaseT    phase;
	pcT               pc;
	logic             halted;
	logic             debugActive;
	logic             debugAck;
	int               cycles = 0;

	seqTop dut0 (
		.clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.dbg(dbg), .bkpEn(bkpEn), .bkpAddr(bkpAddr), .watchEn(watchEn), .watchAddr(watchAddr),
		.phase(phase), .pc(pc), .halted(halted), .debugActive(debugActive), .debugAck(debugAck)
	);

	bind masterSequencer seqProps props0 (
		.clk(clk), .rstN(rstN), .phase(phase), .halted(halted),
		.debugActive(debugActive), .debugAck(debugAck)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			abortRun("timeout: the core ran past the cycle limit");
		end
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic comparePhase(input seqPkg::phaseT exp, input seqPkg::phaseT act);
		if (act !== exp) begin
			abortRun($sformatf("** Error: phase expected 0x%h actual 0x%h", exp, act));
		end
	endtask

	task automatic comparePc(input pcT exp, input pcT act);
		if (act !== exp) begin
			abortRun($sformatf("** Error: pc expected 0x%h actual 0x%h", exp, act));
		end
	endtask

	task automatic compareFlag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abortRun($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	function automatic isaPkg::instrT makeWord(input isaPkg::opcodeT op, input pcT field);
		isaPkg::instrT w;
		w = '0;
		w.jump.opcode = op;
		w.jump.target = field;
		return w;
	endfunction

	function automatic isaPkg::instrT loadWord(input pcT addr);
		isaPkg::instrT w;
		w = '0;
		w.load.opcode   = isaPkg::LOAD;
		w.load.dataAddr = addr;
		return w;
	endfunction

	task automatic writeWord(input pcT addr, input isaPkg::instrT w);
		imemWe   = 1'b1;
		imemAddr = addr;
		imemData = w;
		step();
		imemWe   = 1'b0;
	endtask

	// nops and loads, load addresses stay below 0x80.
	task automatic loadRandom(input pcT first, input int count);
		pcT          a;
		logic [31:0] rnd;
		a = first;
		repeat (count) begin
			rnd = $urandom;
			if (rnd[0]) begin
				writeWord(a, loadWord({1'b0, rnd[`SEQ_PC_W-1:1]}));
			end else begin
				writeWord(a, makeWord(isaPkg::NOP, rnd[`SEQ_PC_W+7:8]));
			end
			a++;
		end
	endtask

	task automatic holdReset();
		repeat (4) step();
		comparePhase(phStop, phase);
		comparePc('0, pc);
		compareFlag("halted", 1'b0, halted);
		compareFlag("debugActive", 1'b0, debugActive);
		compareFlag("debugAck", 1'b0, debugAck);
		rstN = 1'b1;
	endtask

	task automatic phaseStep(input seqPkg::phaseT expPh, input pcT expPc, input logic expActive);
		step();
		comparePhase(expPh, phase);
		comparePc(expPc, pc);
		compareFlag("halted", 1'b0, halted);
		compareFlag("debugActive", expActive, debugActive);
		compareFlag("debugAck", 1'b0, debugAck);
	endtask

	task automatic runInstr(input pcT expPc, input logic expActive);
		phaseStep(phFetch, expPc, expActive);
		dbg.modeInc = 1'b0; // one pulse per step.
		phaseStep(phDec, expPc, expActive);
		phaseStep(phExe, expPc, expActive);
		phaseStep(phCom, expPc, expActive);
	endtask

	task automatic stopStep(input pcT expPc, input logic expAck);
		step();
		comparePhase(phStop, phase);
		comparePc(expPc, pc);
		compareFlag("halted", 1'b0, halted);
		compareFlag("debugActive", 1'b1, debugActive);
		compareFlag("debugAck", expAck, debugAck);
	endtask

	task automatic testRing();
		pcT a;
		rstN = 1'b0;
		loadRandom('0, 8);
		holdReset();
		for (a = '0; a < pcT'(8); a++) begin
			runInstr(a, 1'b0);
		end
		phaseStep(phFetch, pcT'(8), 1'b0);
	endtask

	task automatic testJumpHalt();
		rstN = 1'b0;
		writeWord('0, makeWord(isaPkg::NOP, '0));
		writeWord(pcT'(1), makeWord(isaPkg::JMP, jmpTarget));
		writeWord(jmpTarget, makeWord(isaPkg::NOP, '0));
		writeWord(pcT'(jmpTarget + 1), makeWord(isaPkg::HALT, '0));
		holdReset();
		runInstr('0, 1'b0);
		runInstr(pcT'(1), 1'b0);
		runInstr(jmpTarget, 1'b0);
		runInstr(pcT'(jmpTarget + 1), 1'b0);
		repeat (20) begin
			step();
			comparePhase(phStop, phase);
			comparePc(pcT'(jmpTarget + 1), pc);
			compareFlag("halted", 1'b1, halted);
			compareFlag("debugActive", 1'b0, debugActive);
			compareFlag("debugAck", 1'b0, debugAck);
		end
	endtask

	task automatic testStopStep();
		pcT a;
		rstN = 1'b0;
		loadRandom('0, 16);
		holdReset();
		runInstr('0, 1'b0);
		dbg.modeStop = 1'b1;
		stopStep(pcT'(1), 1'b1);
		repeat (3) stopStep(pcT'(1), 1'b0);
		for (a = pcT'(1); a < pcT'(3); a++) begin
			dbg.modeInc = 1'b1;
			runInstr(a, 1'b1);
			stopStep(pcT'(a + 1), 1'b1);
			stopStep(pcT'(a + 1), 1'b0);
		end
		dbg.modeStop = 1'b0;
		runInstr(pcT'(3), 1'b0);
		runInstr(pcT'(4), 1'b0);
	endtask

	task automatic testBreakpoint();
		pcT          a;
		pcT          bkp;
		logic [31:0] rnd;
		rstN = 1'b0;
		rnd = $urandom;
		bkp = pcT'(rnd % 8 + 2);
		bkpEn   = 1'b1;
		bkpAddr = bkp;
		loadRandom('0, 16);
		holdReset();
		for (a = '0; a <= bkp; a++) begin
			runInstr(a, 1'b0);
		end
		stopStep(pcT'(bkp + 1), 1'b1);
		repeat (2) stopStep(pcT'(bkp + 1), 1'b0); // hit is held until a fetch.
		dbg.modeInc = 1'b1;
		runInstr(pcT'(bkp + 1), 1'b1);
		stopStep(pcT'(bkp + 2), 1'b1);
		runInstr(pcT'(bkp + 2), 1'b0);
	endtask

	task automatic testWatchReq();
		pcT          a;
		logic [31:0] rnd;
		rstN = 1'b0;
		rnd = $urandom;
		bkpEn     = 1'b0;
		watchEn   = 1'b1;
		watchAddr = {1'b1, rnd[`SEQ_PC_W-2:0]};
		loadRandom('0, 12);
		writeWord(pcT'(4), loadWord(watchAddr));
		holdReset();
		for (a = '0; a < pcT'(5); a++) begin
			runInstr(a, 1'b0);
		end
		stopStep(pcT'(5), 1'b1);
		stopStep(pcT'(5), 1'b0);

		// request pulse mid-instruction, both matchers off.
		rstN = 1'b0;
		watchEn = 1'b0;
		loadRandom('0, 12);
		holdReset();
		runInstr('0, 1'b0);
		phaseStep(phFetch, pcT'(1), 1'b0);
		dbg.debugReq = 1'b1;
		phaseStep(phDec, pcT'(1), 1'b0);
		dbg.debugReq = 1'b0;
		phaseStep(phExe, pcT'(1), 1'b0);
		phaseStep(phCom, pcT'(1), 1'b0);
		stopStep(pcT'(2), 1'b1);
		repeat (3) stopStep(pcT'(2), 1'b0);
	endtask

	initial begin
		pcT a;
		void'($urandom(32'hcea2_faa5));
		rstN      = 1'b0;
		imemWe    = 1'b0;
		imemAddr  = '0;
		imemData  = '0;
		dbg       = '0;
		bkpEn     = 1'b0;
		bkpAddr   = '0;
		watchEn   = 1'b0;
		watchAddr = '0;
		a = '0;
		// nops everywhere, address kept in the low field.
		repeat (`SEQ_IMEM_DEPTH) begin
			writeWord(a, makeWord(isaPkg::NOP, a));
			a++;
		end
		testRing();
		testJumpHalt();
		testStopStep();
		testBreakpoint();
		testWatchReq();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
seqPkg.sv
isaPkg.sv
masterSequencer.sv
instrFetch.sv
instrDecode.sv
debugMatch.sv
programCounter.sv
seqTop.sv
seq_properties.sv
seqTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module seqTb -f project.f -o seqSim &&
	./obj_dir/seqSim ||
	{ echo "simulation did not pass"; exit 1; }
